// File: filelist.f
+incdir+dv
common/isaPkg.sv
common/pipePkg.sv
hw/regFile.sv
decode/hazardUnit.sv
decode/branchUnit.sv
decode/decodeStage.sv
dv/tbDecode.sv

// File: Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tbDecode
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) dv/tbTasks.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tbTasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////////////////////////
// Reference rules
//////////////////////////////////////////////////
function automatic instrT regWord(opcodeT op, regIdxT dest, regIdxT src1, regIdxT src2);
  instrT w;
  w = '0;
  w.regForm.opcode = op;
  w.regForm.dest   = dest;
  w.regForm.src1   = src1;
  w.regForm.src2   = src2;
  return w;
endfunction

function automatic instrT immWord(opcodeT op, regIdxT dest, regIdxT src1, dataT imm);
  instrT w;
  w.immForm.opcode = op;
  w.immForm.dest   = dest;
  w.immForm.src1   = src1;
  w.immForm.imm    = imm;
  return w;
endfunction

function automatic logic writesReg(opcodeT op);
  return op inside {opAdd, opAnd, opAddi, opAndi, opMovi, opLdw};
endfunction

function automatic ccT ccOf(dataT v);
  if (v[regWidth-1]) return 3'b100;  // n
  if (v == '0) return 3'b010;        // z
  return 3'b001;                     // p
endfunction

function automatic dataT randomWord();
  return dataT'($urandom);
endfunction

function automatic issueBundleT buildIssue(dataT pc, opcodeT op, dataT s1, dataT s2,
                                           dataT imm, regIdxT dest, logic writes);
  issueBundleT b;
  b.valid      = 1'b1;
  b.pc         = pc;
  b.opcode     = op;
  b.src1Value  = s1;
  b.src2Value  = s2;
  b.imm        = imm;
  b.destIdx    = dest;
  b.writesDest = writes;
  return b;
endfunction

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////
task automatic checkIssue(input issueBundleT expected, input logic careSrc1,
                          input logic careSrc2);
  issueBundleT actual;
  issueBundleT want;
  actual = issueOut;
  want   = expected;
  if (!careSrc1) begin
    actual.src1Value = '0;  // No first source for this opcode
    want.src1Value   = '0;
  end
  if (!careSrc2) begin
    actual.src2Value = '0;
    want.src2Value   = '0;
  end
  if (actual !== want) begin
    stopOnError($sformatf("Fail %s: issueOut expected %h actual %h",
                          testName, want, actual));
  end
endtask

task automatic checkRedirect(input redirectT expected);
  if (redirectOut !== expected) begin
    stopOnError($sformatf("Fail %s: redirectOut expected %h actual %h",
                          testName, expected, redirectOut));
  end
endtask

task automatic checkBit(input string what, input logic actual, input logic expected);
  if (actual !== expected) begin
    stopOnError($sformatf("Fail %s: %s expected %b actual %b",
                          testName, what, expected, actual));
  end
endtask

//////////////////////////////////////////////////
// Drive and wait
//////////////////////////////////////////////////
task automatic present(input dataT pc, input instrT word);
  @(posedge I_CLOCK);
  fetchIn.valid <= 1'b1;
  fetchIn.pc    <= pc;
  fetchIn.instr <= word;
  wbIn.enable   <= 1'b0;
  @(negedge I_CLOCK);
endtask

task automatic idle();
  @(posedge I_CLOCK);
  wbIn.enable <= 1'b0;
  @(negedge I_CLOCK);
endtask

// Writeback model, updates the shadow state as the DUT will at the edge
task automatic writeBack(input regIdxT idx, input dataT data);
  @(posedge I_CLOCK);
  wbIn.enable <= 1'b1;
  wbIn.idx    <= idx;
  wbIn.data   <= data;
  shadowRegs[idx]    = data;
  shadowPending[idx] = 1'b0;
  shadowCc           = ccOf(data);
  @(negedge I_CLOCK);
endtask

task automatic holdCycles(input int n, input logic expDep, input logic expBranch);
  for (int i = 0; i < n; i++) begin
    idle();
    checkBit("depStall while held", depStall, expDep);
    checkBit("branchStall while held", branchStall, expBranch);
  end
endtask

// Accepted at the first edge that sees depStall low
task automatic waitAccept(input instrT word);
  int cycles;
  cycles = 0;
  while (depStall) begin
    if (cycles == acceptTimeout) begin
      stopOnError($sformatf("Timeout in %s: depStall never dropped", testName));
    end
    idle();
    cycles++;
  end
  @(posedge I_CLOCK);
  fetchIn.valid <= 1'b0;
  wbIn.enable   <= 1'b0;
  if (writesReg(word.immForm.opcode)) begin
    shadowPending[word.immForm.dest] = 1'b1;
  end
  @(negedge I_CLOCK);
endtask

task automatic sendInstr(input dataT pc, input instrT word);
  present(pc, word);
  waitAccept(word);
endtask

task automatic loadReg(input regIdxT idx, input dataT data);
  sendInstr(16'h0000, immWord(opMovi, idx, 4'd0, '0));  // Producer first
  writeBack(idx, data);
endtask

task automatic drainPending();
  for (int i = 0; i < numRegs; i++) begin
    if (shadowPending[i]) begin
      writeBack(regIdxT'(i), randomWord());
    end
  end
  idle();
endtask

// Redirect pulse and no issue behind it
task automatic expectRedirect(input logic taken, input dataT target);
  redirectT exp;
  exp.valid  = 1'b1;
  exp.taken  = taken;
  exp.target = target;
  checkRedirect(exp);
  checkBit("issueOut.valid after branch", issueOut.valid, 1'b0);
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////
task automatic testResetIssue();
  instrT word;
  dataT  imm;
  testName = "resetIssue";
  checkBit("issueOut.valid after reset", issueOut.valid, 1'b0);
  checkBit("redirectOut.valid after reset", redirectOut.valid, 1'b0);
  imm  = randomWord();
  word = immWord(opMovi, 4'd1, 4'd0, imm);
  present(16'h0010, word);
  checkBit("depStall on MOVI", depStall, 1'b0);
  waitAccept(word);
  checkIssue(buildIssue(16'h0010, opMovi, '0, '0, imm, 4'd1, 1'b1), 1'b0, 1'b0);
  drainPending();
endtask

task automatic testOperandRead();
  dataT imm;
  testName = "operandRead";
  for (int i = 1; i <= 6; i++) begin
    loadReg(regIdxT'(i), randomWord());
  end
  sendInstr(16'h0100, regWord(opAdd, 4'd10, 4'd1, 4'd2));
  checkIssue(buildIssue(16'h0100, opAdd, shadowRegs[1], shadowRegs[2], '0, 4'd10, 1'b1),
             1'b1, 1'b1);
  sendInstr(16'h0104, regWord(opAnd, 4'd11, 4'd3, 4'd4));
  checkIssue(buildIssue(16'h0104, opAnd, shadowRegs[3], shadowRegs[4], '0, 4'd11, 1'b1),
             1'b1, 1'b1);
  imm = randomWord();
  sendInstr(16'h0108, immWord(opAddi, 4'd12, 4'd5, imm));
  checkIssue(buildIssue(16'h0108, opAddi, shadowRegs[5], '0, imm, 4'd12, 1'b1), 1'b1, 1'b0);
  imm = randomWord();
  sendInstr(16'h010c, immWord(opAndi, 4'd13, 4'd6, imm));
  checkIssue(buildIssue(16'h010c, opAndi, shadowRegs[6], '0, imm, 4'd13, 1'b1), 1'b1, 1'b0);
  imm = randomWord();
  sendInstr(16'h0110, immWord(opLdw, 4'd14, 4'd2, imm));
  checkIssue(buildIssue(16'h0110, opLdw, shadowRegs[2], '0, imm, 4'd14, 1'b1), 1'b1, 1'b0);
  imm = randomWord();
  sendInstr(16'h0114, immWord(opStw, 4'd6, 4'd1, imm));  // Store data from r6
  checkIssue(buildIssue(16'h0114, opStw, shadowRegs[1], shadowRegs[6], imm, 4'd6, 1'b0),
             1'b1, 1'b1);
  drainPending();
endtask

task automatic testDepStall();
  instrT addWord;
  dataT  v;
  testName = "depStall";
  sendInstr(16'h0200, immWord(opAddi, 4'd3, 4'd1, randomWord()));
  addWord = regWord(opAdd, 4'd5, 4'd3, 4'd2);
  present(16'h0204, addWord);
  checkBit("depStall on pending r3", depStall, 1'b1);
  holdCycles(2 + int'($urandom % 3), 1'b1, 1'b0);
  v = randomWord();
  writeBack(4'd3, v);
  checkBit("depStall in writeback cycle", depStall, 1'b0);  // Bypassed
  waitAccept(addWord);
  checkIssue(buildIssue(16'h0204, opAdd, v, shadowRegs[2], '0, 4'd5, 1'b1), 1'b1, 1'b1);
  drainPending();
endtask

task automatic testCondBranch();
  dataT   values [3];
  dataT   pc;
  dataT   imm;
  instrT  word;
  ccT     mask;
  testName  = "condBranch";
  values[0] = randomWord() | 16'h8000;                 // Negative
  values[1] = '0;
  values[2] = (randomWord() & 16'h7fff) | 16'h0001;    // Positive
  for (int k = 0; k < 3; k++) begin
    sendInstr(16'h0300, immWord(opMovi, 4'd7, 4'd0, '0));
    pc   = randomWord();
    imm  = randomWord();
    word = immWord(opBrnzp, 4'd0, 4'd0, imm);
    present(pc, word);
    holdCycles(2, 1'b1, 1'b1);  // Anything pending blocks a BR
    writeBack(4'd7, values[k]);
    checkBit("depStall while cc producer writes back", depStall, 1'b1);
    waitAccept(word);
    expectRedirect(1'b1, pc + imm);
    for (int m = 1; m < 7; m++) begin
      mask = ccT'(m);
      pc   = randomWord();
      imm  = randomWord();
      word = immWord(opcodeT'({5'b01000, mask}), 4'd0, 4'd0, imm);  // BR with n/z/p mask
      sendInstr(pc, word);
      expectRedirect((mask & shadowCc) != '0, pc + imm);
    end
  end
endtask

task automatic testJump();
  instrT word;
  dataT  pc;
  dataT  base;
  testName = "jump";
  sendInstr(16'h0400, immWord(opMovi, 4'd9, 4'd0, '0));
  pc   = randomWord();
  word = immWord(opJmp, 4'd0, 4'd9, randomWord());  // imm must be ignored
  present(pc, word);
  checkBit("branchStall with JMP present", branchStall, 1'b1);
  holdCycles(3, 1'b1, 1'b1);
  base = randomWord();
  writeBack(4'd9, base);
  checkBit("depStall in base writeback cycle", depStall, 1'b0);
  checkBit("branchStall in base writeback cycle", branchStall, 1'b1);
  waitAccept(word);
  expectRedirect(1'b1, base);
  checkBit("branchStall after JMP accepted", branchStall, 1'b0);
endtask

`endif

// File: dv/tbDecode.sv
`timescale 1ns/1ns

module tbDecode;

  import isaPkg::*;
  import pipePkg::*;

  localparam int acceptTimeout = 20;  // Max cycles a word may sit stalled

  logic        I_CLOCK = 1'b0;
  logic        reset;
  fetchBundleT fetchIn;
  wbBundleT    wbIn;
  issueBundleT issueOut;
  redirectT    redirectOut;
  logic        depStall;
  logic        branchStall;

  // Writeback model and reference state
  dataT               shadowRegs [numRegs];
  logic [numRegs-1:0] shadowPending;
  ccT                 shadowCc;       // Zero until the first writeback
  string              testName;

  always #50 I_CLOCK = ~I_CLOCK;  // 100 ns period

  decodeStage dut_i (
    .I_CLOCK     (I_CLOCK),
    .reset       (reset),
    .fetchIn     (fetchIn),
    .wbIn        (wbIn),
    .issueOut    (issueOut),
    .redirectOut (redirectOut),
    .depStall    (depStall),
    .branchStall (branchStall)
  );

  task automatic stopOnError(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  `include "tbTasks.svh"

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(32'hd6d111da));
    reset         = 1'b1;
    fetchIn       = '0;
    wbIn          = '0;
    shadowPending = '0;
    shadowCc      = '0;
    testName      = "reset";
    for (int i = 0; i < numRegs; i++) begin
      shadowRegs[i] = '0;  // Register file clears on reset
    end
    repeat (8) @(posedge I_CLOCK);
    reset <= 1'b0;
    @(negedge I_CLOCK);  // All sampling happens mid-cycle
    testResetIssue();
    testOperandRead();
    testDepStall();
    testCondBranch();
    testJump();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: decode/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
  input  logic                 I_CLOCK,
  input  logic                 reset,
  input  pipePkg::fetchBundleT fetchIn,
  input  pipePkg::wbBundleT    wbIn,
  output pipePkg::issueBundleT issueOut,
  output pipePkg::redirectT    redirectOut,
  output logic                 depStall,
  output logic                 branchStall
);

  import isaPkg::*;
  import pipePkg::*;

  instrT                instr;
  opcodeT               opcode;
  regIdxT               src1Idx;
  regIdxT               src2Idx;
  regIdxT               destIdx;
  regIdxT               jumpIdx;
  logic [immWidth-1:0]  imm;
  logic                 isRegForm;
  logic                 useSrc1;
  logic                 useSrc2;
  logic                 writesDest;
  logic                 isCondBranch;
  logic                 isJmp;
  logic                 isBranch;
  logic                 accept;
  logic                 issueAccept;
  logic                 branchAccept;
  dataT                 src1Value;
  dataT                 src2Value;
  dataT                 jumpBase;

  //////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////
  assign instr     = fetchIn.instr;
  assign opcode    = instr.regForm.opcode;  // Same bits in both views
  assign isRegForm = (opcode == opAdd) || (opcode == opAnd);
  assign destIdx   = instr.immForm.dest;
  assign jumpIdx   = instr.immForm.src1;    // JMP base register
  assign imm       = isRegForm ? '0 : instr.immForm.imm;

  always_comb begin
    useSrc1      = 1'b0;
    useSrc2      = 1'b0;
    writesDest   = 1'b0;
    isCondBranch = 1'b0;
    isJmp        = 1'b0;
    src1Idx      = instr.immForm.src1;
    src2Idx      = instr.regForm.src2;
    case (opcode)
      opAdd, opAnd: begin
        useSrc1    = 1'b1;
        useSrc2    = 1'b1;
        writesDest = 1'b1;
      end
      opAddi, opAndi, opLdw: begin
        useSrc1    = 1'b1;
        writesDest = 1'b1;
      end
      opMovi: writesDest = 1'b1;  // No source
      opStw: begin
        useSrc1 = 1'b1;                 // Address base
        useSrc2 = 1'b1;
        src2Idx = instr.immForm.dest;   // Store data sits in the dest field
      end
      opBrn, opBrz, opBrp, opBrnz, opBrnp, opBrzp, opBrnzp: isCondBranch = 1'b1;
      opJmp: begin
        useSrc1 = 1'b1;  // Stall on the base only
        isJmp   = 1'b1;
      end
      default: ;  // Unknown word issues as a no-write op
    endcase
  end

  // Handshake with fetch
  assign isBranch     = isCondBranch || isJmp;
  assign branchStall  = fetchIn.valid && isBranch;  // Hold PC until redirect
  assign accept       = fetchIn.valid && !depStall;
  assign issueAccept  = accept && !isBranch;
  assign branchAccept = accept && isBranch;

  //////////////////////////////////////////////////
  // Submodules
  //////////////////////////////////////////////////
  regFile regFile_i (
    .I_CLOCK (I_CLOCK),
    .reset   (reset),
    .wbIn    (wbIn),
    .rdIdxA  (src1Idx),
    .rdIdxB  (src2Idx),
    .rdIdxC  (jumpIdx),
    .rdDataA (src1Value),
    .rdDataB (src2Value),
    .rdDataC (jumpBase)
  );

  hazardUnit hazardUnit_i (
    .I_CLOCK      (I_CLOCK),
    .reset        (reset),
    .src1Idx      (src1Idx),
    .src2Idx      (src2Idx),
    .useSrc1      (fetchIn.valid && useSrc1),
    .useSrc2      (fetchIn.valid && useSrc2),
    .isCondBranch (fetchIn.valid && isCondBranch),
    .accept       (accept),
    .writesDest   (writesDest),
    .destIdx      (destIdx),
    .wbIn         (wbIn),
    .depStall     (depStall),
    .anyPending   ()
  );

  branchUnit branchUnit_i (
    .I_CLOCK     (I_CLOCK),
    .reset       (reset),
    .accept      (branchAccept),
    .opcode      (opcode),
    .pc          (fetchIn.pc),
    .imm         (imm),
    .jumpBase    (jumpBase),
    .wbIn        (wbIn),
    .redirectOut (redirectOut)
  );

  //////////////////////////////////////////////////
  // Issue register
  //////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (reset) begin
      issueOut.valid <= 1'b0;
    end else begin
      issueOut.valid <= issueAccept;  // One-cycle pulse
      if (issueAccept) begin
        issueOut.pc         <= fetchIn.pc;
        issueOut.opcode     <= opcode;
        issueOut.src1Value  <= src1Value;
        issueOut.src2Value  <= src2Value;
        issueOut.imm        <= imm;
        issueOut.destIdx    <= destIdx;
        issueOut.writesDest <= writesDest;
      end
    end
  end

  // A stalled cycle never produces an issue
  noIssueAfterStall: assert property (
    @(posedge I_CLOCK) disable iff (reset)
    depStall |=> !issueOut.valid
  );

endmodule

// File: decode/branchUnit.sv
`timescale 1ns/1ns

module branchUnit (
  input  logic              I_CLOCK,
  input  logic              reset,
  input  logic              accept,    // Branch or jump taken in this cycle
  input  isaPkg::opcodeT    opcode,
  input  isaPkg::dataT      pc,
  input  isaPkg::dataT      imm,
  input  isaPkg::dataT      jumpBase,
  input  pipePkg::wbBundleT wbIn,
  output pipePkg::redirectT redirectOut
);

  import isaPkg::*;
  import pipePkg::*;

  ccT   cc;        // Set by last scalar writeback
  ccT   brMask;
  logic isJmp;
  logic taken;
  dataT target;

  //////////////////////////////////////////////////
  // Condition code
  //////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (reset) begin
      cc <= '0;  // Nothing written back yet
    end else if (wbIn.enable) begin
      if (wbIn.data[regWidth-1]) begin
        cc <= ccNeg;
      end else if (wbIn.data == '0) begin
        cc <= ccZero;
      end else begin
        cc <= ccPos;
      end
    end
  end

  //////////////////////////////////////////////////
  // Condition test and target
  //////////////////////////////////////////////////
  always_comb begin
    case (opcode)
      opBrn:   brMask = ccNeg;
      opBrz:   brMask = ccZero;
      opBrp:   brMask = ccPos;
      opBrnz:  brMask = ccNeg | ccZero;
      opBrnp:  brMask = ccNeg | ccPos;
      opBrzp:  brMask = ccZero | ccPos;
      opBrnzp: brMask = ccNeg | ccZero | ccPos;
      default: brMask = '0;  // JMP and non-branches
    endcase
    isJmp = (opcode == opJmp);
    // BRNZP goes even before any writeback
    taken  = isJmp || (opcode == opBrnzp) || |(brMask & cc);
    target = isJmp ? jumpBase : dataT'(pc + imm);  // PC-relative for BR
  end

  // Redirect pulse, one cycle after acceptance
  always_ff @(posedge I_CLOCK) begin
    if (reset) begin
      redirectOut.valid <= 1'b0;
    end else begin
      redirectOut.valid <= accept;
      if (accept) begin
        redirectOut.taken  <= taken;
        redirectOut.target <= target;
      end
    end
  end

  ccLegal: assert property (
    @(posedge I_CLOCK) disable iff (reset)
    $onehot0(cc)
  );

endmodule

// File: decode/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
  input  logic              I_CLOCK,
  input  logic              reset,
  input  isaPkg::regIdxT    src1Idx,
  input  isaPkg::regIdxT    src2Idx,
  input  logic              useSrc1,
  input  logic              useSrc2,
  input  logic              isCondBranch,
  input  logic              accept,
  input  logic              writesDest,
  input  isaPkg::regIdxT    destIdx,
  input  pipePkg::wbBundleT wbIn,
  output logic              depStall,
  output logic              anyPending
);

  import isaPkg::*;
  import pipePkg::*;

  logic [numRegs-1:0] pending;  // One bit per register in flight
  logic               src1Stall;
  logic               src2Stall;
  logic               ccStall;

  //////////////////////////////////////////////////
  // Scoreboard
  //////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (reset) begin
      pending <= '0;
    end else begin
      if (wbIn.enable) begin
        pending[wbIn.idx] <= 1'b0;  // Result is back
      end
      // Set comes last so a new producer beats a same-cycle writeback
      if (accept && writesDest) begin
        pending[destIdx] <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stall decision
  //////////////////////////////////////////////////
  // Pending source stalls unless its value arrives this cycle
  function automatic logic srcStall(logic used, regIdxT idx);
    logic wbHit;
    wbHit = wbIn.enable && (wbIn.idx == idx);
    return used && pending[idx] && !wbHit;
  endfunction

  always_comb begin
    src1Stall  = srcStall(useSrc1, src1Idx);
    src2Stall  = srcStall(useSrc2, src2Idx);
    anyPending = |pending;
    // The condition code settles only when nothing is in flight,
    // a writeback in this cycle still updates it too late
    ccStall    = isCondBranch && anyPending;
    depStall   = src1Stall || src2Stall || ccStall;
  end

  // Every writeback must match an issued producer
  wbHasProducer: assert property (
    @(posedge I_CLOCK) disable iff (reset)
    wbIn.enable |-> pending[wbIn.idx]
  );

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ns

module regFile (
  input  logic              I_CLOCK,
  input  logic              reset,
  input  pipePkg::wbBundleT wbIn,
  input  isaPkg::regIdxT    rdIdxA,
  input  isaPkg::regIdxT    rdIdxB,
  input  isaPkg::regIdxT    rdIdxC,
  output isaPkg::dataT      rdDataA,
  output isaPkg::dataT      rdDataB,
  output isaPkg::dataT      rdDataC
);

  import isaPkg::*;
  import pipePkg::*;

  dataT regs [numRegs];  // Scalar registers

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (reset) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wbIn.enable) begin
      regs[wbIn.idx] <= wbIn.data;  // Lands at the edge
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////
  // Same-cycle writeback bypasses the array
  function automatic dataT readPort(regIdxT idx);
    dataT value;
    if (wbIn.enable && (wbIn.idx == idx)) begin
      value = wbIn.data;  // Write-through
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  always_comb begin
    rdDataA = readPort(rdIdxA);  // src1
    rdDataB = readPort(rdIdxB);  // src2 or STW data
    rdDataC = readPort(rdIdxC);  // Jump base
  end

endmodule

// File: common/pipePkg.sv
package pipePkg;

  //////////////////////////////////////////////////
  // Fetch to decode
  //////////////////////////////////////////////////
  typedef struct packed {
    logic                          valid;  // Held while depStall
    logic [isaPkg::pcWidth-1:0]    pc;
    isaPkg::instrT                 instr;
  } fetchBundleT;

  //////////////////////////////////////////////////
  // Writeback to decode
  //////////////////////////////////////////////////
  typedef struct packed {
    logic            enable;
    isaPkg::regIdxT  idx;
    isaPkg::dataT    data;  // Also sets the condition code
  } wbBundleT;

  //////////////////////////////////////////////////
  // Decode to execute, registered, no back-pressure
  //////////////////////////////////////////////////
  typedef struct packed {
    logic                          valid;
    logic [isaPkg::pcWidth-1:0]    pc;
    isaPkg::opcodeT                opcode;
    isaPkg::dataT                  src1Value;
    isaPkg::dataT                  src2Value;   // STW store data lands here
    logic [isaPkg::immWidth-1:0]   imm;
    isaPkg::regIdxT                destIdx;
    logic                          writesDest;
  } issueBundleT;

  // Decode back to fetch, one cycle pulse per branch
  typedef struct packed {
    logic                          valid;
    logic                          taken;
    logic [isaPkg::pcWidth-1:0]    target;
  } redirectT;

endpackage

// File: common/isaPkg.sv
package isaPkg;

  //////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////
  localparam int regWidth    = 16;  // Scalar data path
  localparam int numRegs     = 16;  // r0..r15
  localparam int regIdxWidth = 4;
  localparam int pcWidth     = 16;
  localparam int opcodeWidth = 8;
  localparam int immWidth    = 16;

  typedef logic [regIdxWidth-1:0] regIdxT;
  typedef logic [regWidth-1:0]    dataT;

  // Condition code, one-hot n/z/p, zero means nothing written back yet
  typedef logic [2:0] ccT;
  localparam ccT ccNeg  = 3'b100;
  localparam ccT ccZero = 3'b010;
  localparam ccT ccPos  = 3'b001;

  //////////////////////////////////////////////////
  // Opcodes kept from the scalar integer path
  //////////////////////////////////////////////////
  typedef enum logic [opcodeWidth-1:0] {
    opAdd   = 8'h10,  // Register form
    opAddi  = 8'h11,
    opAnd   = 8'h12,  // Register form
    opAndi  = 8'h13,
    opMovi  = 8'h20,
    opLdw   = 8'h30,  // dest <- mem[src1 + imm]
    opStw   = 8'h31,  // mem[src1 + imm] <- dest field register
    opBrp   = 8'h41,  // Low three bits of BR opcodes follow n/z/p
    opBrz   = 8'h42,
    opBrzp  = 8'h43,
    opBrn   = 8'h44,
    opBrnp  = 8'h45,
    opBrnz  = 8'h46,
    opBrnzp = 8'h47,
    opJmp   = 8'h50   // Target is register src1
  } opcodeT;

  // ADD, AND: two source registers
  typedef struct packed {
    opcodeT         opcode;  // 31:24
    regIdxT         dest;    // 23:20
    regIdxT         src1;    // 19:16
    logic [3:0]     spareA;
    regIdxT         src2;    // 11:8
    logic [7:0]     spareB;
  } regFormT;

  // Everything else: one source plus a 16-bit immediate
  typedef struct packed {
    opcodeT                opcode;
    regIdxT                dest;
    regIdxT                src1;
    logic [immWidth-1:0]   imm;
  } immFormT;

  // Same 32-bit word, decoded by opcode
  typedef union packed {
    regFormT regForm;
    immFormT immForm;
  } instrT;

endpackage
